// ==== sim.f ====
+incdir+src
src/dup_mem_pkg.sv
src/dup_init_seq.sv
src/dup_sram_copy.sv
src/dup_read_return.sv
src/dup_refresh_sched.sv
src/dup_mem_top.sv
verif/dup_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the duplicated two-read memory

VERILATOR ?= verilator
TOP       ?= dup_mem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/dup_mem_tb.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_mem_tb;
  import dup_mem_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int INIT_CYCLES  = `DUP_NUMADDR;  // one clear per word
  localparam int RSP_STAGES   = `DUP_SRAM_DELAY + 1;
  localparam int NUM_WRITES   = 40;
  localparam int NUM_READS    = 40;
  localparam int NUM_DUAL     = 64;
  localparam int NUM_COLLIDE  = 8;
  localparam int NUM_REFRESH  = 5;
  localparam int REFRESH_GAP  = 4;
  localparam int DRAIN_CYCLES = 4;
  localparam int TEST_CYCLES  = INIT_CYCLES + NUM_WRITES + NUM_READS + NUM_DUAL
                              + 3 * NUM_COLLIDE + NUM_REFRESH * (REFRESH_GAP + 1)
                              + 6 * DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + INIT_CYCLES + 1 + TEST_CYCLES + 64;

  logic                                      clk;
  logic                                      reset;
  logic                                      write;
  logic [`DUP_BITADDR-1:0]                   wr_adr;
  logic [`DUP_WIDTH-1:0]                     din;
  logic [`DUP_NUMRDPT-1:0]                   read;
  logic [`DUP_NUMRDPT-1:0][`DUP_BITADDR-1:0] rd_adr;
  logic                                      refr;
  logic                                      ready;
  rd_rsp_t                                   rd_rsp [`DUP_NUMRDPT];
  logic                                      refr_strobe;
  logic [`DUP_BITRBNK-1:0]                   refr_bank;

  logic [15:0]             lfsr;
  int                      cycle_cnt;
  int                      reset_edges;
  int                      since_rst;
  logic                    ready_exp;
  logic [`DUP_WIDTH-1:0]   model [`DUP_NUMADDR];
  rd_rsp_t                 exp_pipe [`DUP_NUMRDPT][RSP_STAGES];
  logic [1:0]              refr_pipe;
  logic [`DUP_BITRBNK-1:0] exp_ptr;
  logic [`DUP_BITRBNK-1:0] exp_bank;
  logic [`DUP_BITRBNK-1:0] bank_log [$];

  dup_mem_top UUT (
    .clk         (clk),
    .reset       (reset),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .read        (read),
    .rd_adr      (rd_adr),
    .refr        (refr),
    .ready       (ready),
    .rd_rsp      (rd_rsp),
    .refr_strobe (refr_strobe),
    .refr_bank   (refr_bank)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;  // galois form, taps 16 14 13 11
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic drive_cycle(input logic w, input logic [`DUP_BITADDR-1:0] wa,
                             input logic [`DUP_WIDTH-1:0] d, input logic [`DUP_NUMRDPT-1:0] rd,
                             input logic [`DUP_NUMRDPT-1:0][`DUP_BITADDR-1:0] ra,
                             input logic rf);
    @(posedge clk);
    write  <= w;
    wr_adr <= wa;
    din    <= d;
    read   <= rd;
    rd_adr <= ra;
    refr   <= rf;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, '0, '0, 1'b0);
  endtask

  function automatic bit banks_in_order();
    if (bank_log.size() != NUM_REFRESH) return 1'b0;
    for (int i = 0; i < NUM_REFRESH; i++) begin
      if (bank_log[i] != `DUP_BITRBNK'(i % `DUP_NUMRBNK)) return 1'b0;
    end
    return 1'b1;
  endfunction

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset) begin
      reset_edges <= reset_edges + 1;
      since_rst   <= 0;
    end else if (since_rst < INIT_CYCLES) begin
      since_rst <= since_rst + 1;
    end
  end

  always @(posedge clk) begin
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // every word is cleared once before the memory opens for access
  assign ready_exp = !reset && (since_rst >= INIT_CYCLES);

  // reference model, the read sees the word as it was before a same-cycle write
  always @(posedge clk) begin
    if (reset) begin
      for (int a = 0; a < `DUP_NUMADDR; a++) model[a] <= '0;
      for (int p = 0; p < `DUP_NUMRDPT; p++) begin
        for (int s = 0; s < RSP_STAGES; s++) exp_pipe[p][s] <= '0;
      end
    end else begin
      for (int p = 0; p < `DUP_NUMRDPT; p++) begin
        exp_pipe[p][0].vld  <= read[p] && ready_exp;
        exp_pipe[p][0].data <= model[rd_adr[p]];
        exp_pipe[p][0].padr <= {`DUP_BITPORT'(p), rd_adr[p]};
        for (int s = 1; s < RSP_STAGES; s++) exp_pipe[p][s] <= exp_pipe[p][s-1];
      end
      if (write && ready_exp) model[wr_adr] <= din;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      refr_pipe <= '0;
      exp_ptr   <= '0;
      exp_bank  <= '0;
    end else begin
      refr_pipe <= {refr_pipe[0], refr};
      if (refr_pipe[0]) begin
        exp_bank <= exp_ptr;
        exp_ptr  <= exp_ptr + 1'b1;  // four banks wrap with the pointer width
      end
    end
    if (refr_strobe) bank_log.push_back(refr_bank);
  end

  assert property (@(posedge clk) (reset_edges > 0) |-> ready == ready_exp)
    else report_mismatch("ready does not follow reset and initialization");
  assert property (@(posedge clk) (reset_edges > 0) |-> refr_strobe == refr_pipe[1])
    else report_mismatch("refresh strobe at the wrong cycle");
  assert property (@(posedge clk) (reset_edges > 0) |-> refr_bank == exp_bank)
    else report_mismatch($sformatf("refresh bank %0d, expected %0d", refr_bank, exp_bank));

  for (genvar p = 0; p < `DUP_NUMRDPT; p++) begin : g_check
    assert property (@(posedge clk)
        (reset_edges > 0) |-> rd_rsp[p].vld == exp_pipe[p][RSP_STAGES-1].vld)
      else report_mismatch($sformatf("port %0d response valid is wrong", p));
    assert property (@(posedge clk) (reset_edges > 0 && exp_pipe[p][RSP_STAGES-1].vld)
        |-> rd_rsp[p].data == exp_pipe[p][RSP_STAGES-1].data)
      else report_mismatch($sformatf("port %0d read data %h, expected %h", p,
                                     rd_rsp[p].data, exp_pipe[p][RSP_STAGES-1].data));
    assert property (@(posedge clk) (reset_edges > 0 && exp_pipe[p][RSP_STAGES-1].vld)
        |-> rd_rsp[p].padr == exp_pipe[p][RSP_STAGES-1].padr)
      else report_mismatch($sformatf("port %0d physical address is wrong", p));
  end

  initial begin
    logic [15:0]             r;
    logic [15:0]             x;
    logic [`DUP_BITADDR-1:0] a;
    logic [`DUP_BITADDR-1:0] b;
    logic [`DUP_WIDTH-1:0]   d;
    clk         = 1'b0;
    reset       = 1'b1;
    write       = 1'b0;
    wr_adr      = '0;
    din         = '0;
    read        = '0;
    rd_adr      = '0;
    refr        = 1'b0;
    lfsr        = 16'd72;
    cycle_cnt   = 0;
    reset_edges = 0;
    since_rst   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    while (!ready) @(posedge clk);

    // untouched words read back as zero on both ports
    for (int i = 0; i < INIT_CYCLES; i++) begin
      a = `DUP_BITADDR'(i);
      drive_cycle(1'b0, '0, '0, 2'b11, {a ^ `DUP_BITADDR'(16), a}, 1'b0);
    end
    idle_cycles(DRAIN_CYCLES);

    for (int i = 0; i < NUM_WRITES; i++) begin
      take_bits(`DUP_BITADDR, r);
      take_bits(`DUP_WIDTH, x);
      drive_cycle(1'b1, r[`DUP_BITADDR-1:0], x, '0, '0, 1'b0);
    end
    idle_cycles(DRAIN_CYCLES);
    for (int i = 0; i < NUM_READS; i++) begin
      take_bits(`DUP_BITADDR, r);
      take_bits(`DUP_BITADDR, x);
      drive_cycle(1'b0, '0, '0, 2'b11, {x[`DUP_BITADDR-1:0], r[`DUP_BITADDR-1:0]}, 1'b0);
    end
    idle_cycles(DRAIN_CYCLES);

    // both ports on distinct words every cycle, with writes mixed in
    for (int i = 0; i < NUM_DUAL; i++) begin
      take_bits(`DUP_BITADDR, r);
      take_bits(`DUP_BITADDR, x);
      a = r[`DUP_BITADDR-1:0];
      b = a ^ (x[`DUP_BITADDR-1:0] | `DUP_BITADDR'(1));
      take_bits(`DUP_BITADDR, r);
      take_bits(`DUP_WIDTH, x);
      d = x;
      take_bits(1, x);
      drive_cycle(x[0], r[`DUP_BITADDR-1:0], d, 2'b11, {b, a}, 1'b0);
    end
    idle_cycles(DRAIN_CYCLES);

    for (int i = 0; i < NUM_COLLIDE; i++) begin
      take_bits(`DUP_BITADDR, r);
      take_bits(`DUP_WIDTH, x);
      a = r[`DUP_BITADDR-1:0];
      d = model[a] ^ (x | 16'h0001);  // new word always differs from the old one
      drive_cycle(1'b1, a, d, 2'b11, {a, a}, 1'b0);
      drive_cycle(1'b0, '0, '0, 2'b11, {a, a}, 1'b0);
      idle_cycles(1);
    end
    idle_cycles(DRAIN_CYCLES);

    for (int i = 0; i < NUM_REFRESH; i++) begin
      drive_cycle(1'b0, '0, '0, '0, '0, 1'b1);
      idle_cycles(REFRESH_GAP);
    end
    idle_cycles(DRAIN_CYCLES);

    if (banks_in_order()) begin
      $display("Simulation passed");
      $finish;
    end else begin
      report_mismatch("refresh banks did not step through 0, 1, 2, 3, 0");
    end
  end

endmodule

// ==== src/dup_mem_top.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_mem_top (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     write,
  input  logic [`DUP_BITADDR-1:0]                  wr_adr,
  input  logic [`DUP_WIDTH-1:0]                    din,
  input  logic [`DUP_NUMRDPT-1:0]                  read,
  input  logic [`DUP_NUMRDPT-1:0][`DUP_BITADDR-1:0] rd_adr,
  input  logic                                     refr,
  output logic                                     ready,
  output dup_mem_pkg::rd_rsp_t                     rd_rsp [`DUP_NUMRDPT],
  output logic                                     refr_strobe,
  output logic [`DUP_BITRBNK-1:0]                  refr_bank
);
  import dup_mem_pkg::*;

  wr_cmd_t               wr_cmd;
  rd_req_t               rd_req  [`DUP_NUMRDPT];
  logic [`DUP_WIDTH-1:0] rd_data [`DUP_NUMRDPT];

  dup_init_seq u_init_seq (
    .clk    (clk),
    .reset  (reset),
    .write  (write),
    .wr_adr (wr_adr),
    .din    (din),
    .ready  (ready),
    .wr_cmd (wr_cmd)
  );

  // each read port owns a full copy of the array
  for (genvar p = 0; p < `DUP_NUMRDPT; p++) begin : g_port
    assign rd_req[p].vld  = read[p] & ready;  // reads are dropped during init
    assign rd_req[p].addr = rd_adr[p];

    dup_sram_copy u_copy (
      .clk     (clk),
      .wr_cmd  (wr_cmd),
      .rd_req  (rd_req[p]),
      .rd_data (rd_data[p])
    );

    dup_read_return #(
      .PORT_ID (p)
    ) u_return (
      .clk     (clk),
      .reset   (reset),
      .rd_req  (rd_req[p]),
      .rd_data (rd_data[p]),
      .rd_rsp  (rd_rsp[p])
    );
  end

  dup_refresh_sched u_refresh (
    .clk         (clk),
    .reset       (reset),
    .refr        (refr),
    .refr_strobe (refr_strobe),
    .refr_bank   (refr_bank)
  );

endmodule

// ==== src/dup_refresh_sched.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_refresh_sched (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    refr,
  output logic                    refr_strobe,
  output logic [`DUP_BITRBNK-1:0] refr_bank
);

  logic                    refr_q;
  logic [`DUP_BITRBNK-1:0] bank_ptr;
  logic                    ptr_wrap;

  assign ptr_wrap = (bank_ptr == `DUP_BITRBNK'(`DUP_NUMRBNK - 1));

  // the pulse is captured first and the strobe issued on the next edge
  always_ff @(posedge clk) begin
    if (reset) begin
      refr_q <= 1'b0;
    end else begin
      refr_q <= refr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      refr_strobe <= 1'b0;
      refr_bank   <= '0;
      bank_ptr    <= '0;
    end else begin
      refr_strobe <= refr_q;
      if (refr_q) begin
        refr_bank <= bank_ptr;  // bank holds until the next refresh
        bank_ptr  <= ptr_wrap ? '0 : bank_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== src/dup_read_return.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_read_return #(
  parameter int PORT_ID = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  dup_mem_pkg::rd_req_t  rd_req,
  input  logic [`DUP_WIDTH-1:0] rd_data,
  output dup_mem_pkg::rd_rsp_t  rd_rsp
);

  localparam logic [`DUP_BITPORT-1:0] PORT_SEL = `DUP_BITPORT'(PORT_ID);

  logic [`DUP_SRAM_DELAY:0]                    vld_pipe;
  logic [`DUP_SRAM_DELAY:0][`DUP_BITADDR-1:0]  adr_pipe;

  // valid bits walk alongside the copy's read pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_req.vld;
      for (int i = 1; i <= `DUP_SRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    adr_pipe[0] <= rd_req.addr;
    for (int i = 1; i <= `DUP_SRAM_DELAY; i++) begin
      adr_pipe[i] <= adr_pipe[i-1];
    end
  end

  assign rd_rsp.vld  = vld_pipe[`DUP_SRAM_DELAY];
  assign rd_rsp.data = rd_rsp.vld ? rd_data : '0;  // stale pipeline data stays hidden
  assign rd_rsp.padr = {PORT_SEL, adr_pipe[`DUP_SRAM_DELAY]};

endmodule

// ==== src/dup_sram_copy.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_sram_copy (
  input  logic                  clk,
  input  dup_mem_pkg::wr_cmd_t  wr_cmd,
  input  dup_mem_pkg::rd_req_t  rd_req,
  output logic [`DUP_WIDTH-1:0] rd_data
);
  import dup_mem_pkg::*;

  logic [`DUP_WIDTH-1:0] mem [`DUP_NUMADDR];

  // stage 0 holds the array word and the last of the delay stages feeds the port
  logic [`DUP_SRAM_DELAY:0][`DUP_WIDTH-1:0] rd_pipe;

  always_ff @(posedge clk) begin
    case (wr_cmd.op)
      OP_CLEAR: begin
        mem[wr_cmd.addr] <= '0;
      end
      OP_WRITE: begin
        mem[wr_cmd.addr] <= wr_cmd.data;
      end
      default: begin
      end
    endcase
  end

  // the array is sampled before a same-edge write lands, so a colliding
  // read returns the old word
  always_ff @(posedge clk) begin
    if (rd_req.vld) begin
      rd_pipe[0] <= mem[rd_req.addr];
    end
    for (int i = 1; i <= `DUP_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[`DUP_SRAM_DELAY];

endmodule

// ==== src/dup_init_seq.sv ====
`timescale 1ns/1ps
`include "dup_mem_config.svh"

module dup_init_seq (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    write,
  input  logic [`DUP_BITADDR-1:0] wr_adr,
  input  logic [`DUP_WIDTH-1:0]   din,
  output logic                    ready,
  output dup_mem_pkg::wr_cmd_t    wr_cmd
);
  import dup_mem_pkg::*;

  init_state_e             state;
  init_state_e             state_nxt;
  logic [`DUP_BITADDR-1:0] clr_cnt;
  logic                    clr_last;

  assign clr_last = &clr_cnt;  // address space is a power of two

  always_comb begin
    state_nxt = state;
    case (state)
      INIT_CLEAR: state_nxt = clr_last ? INIT_RUN : INIT_CLEAR;
      INIT_RUN:   state_nxt = INIT_RUN;
      default:    state_nxt = INIT_CLEAR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= INIT_CLEAR;
      clr_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == INIT_CLEAR) begin
        clr_cnt <= clr_cnt + 1'b1;
      end
    end
  end

  // one command feeds every copy, so all copies see the same writes
  always_comb begin
    wr_cmd.op   = OP_IDLE;
    wr_cmd.addr = wr_adr;
    wr_cmd.data = din;
    if (state == INIT_CLEAR) begin
      wr_cmd.op   = OP_CLEAR;
      wr_cmd.addr = clr_cnt;
      wr_cmd.data = '0;
    end else if (write) begin
      wr_cmd.op = OP_WRITE;
    end
  end

  assign ready = (state == INIT_RUN);

endmodule

// ==== src/dup_mem_pkg.sv ====
`include "dup_mem_config.svh"

package dup_mem_pkg;

  typedef enum logic [1:0] {
    OP_IDLE,
    OP_CLEAR,
    OP_WRITE
  } mem_op_e;

  typedef enum logic {
    INIT_CLEAR,
    INIT_RUN
  } init_state_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`DUP_BITADDR-1:0] addr;
    logic [`DUP_WIDTH-1:0]   data;
  } wr_cmd_t;

  typedef struct packed {
    logic                    vld;
    logic [`DUP_BITADDR-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic                    vld;
    logic [`DUP_WIDTH-1:0]   data;
    logic [`DUP_BITPADR-1:0] padr;
  } rd_rsp_t;

endpackage

// ==== src/dup_mem_config.svh ====
`ifndef DUP_MEM_CONFIG_SVH
`define DUP_MEM_CONFIG_SVH

// data word and address space
`define DUP_WIDTH      16
`define DUP_BITADDR    5
`define DUP_NUMADDR    (1 << `DUP_BITADDR)

// one storage copy per read port
`define DUP_NUMRDPT    2
`define DUP_BITPORT    1

`define DUP_SRAM_DELAY 2  // read latency of a copy in cycles

`define DUP_NUMRBNK    4
`define DUP_BITRBNK    2

// physical address is copy index above the row
`define DUP_BITPADR    (`DUP_BITPORT + `DUP_BITADDR)

`endif
